/* rtl/heatmap_pkg.sv */
package heatmap_pkg;

    // Data widths
    localparam int SAMPLE_W   = 16;
    localparam int COLOR_W    = 8;
    localparam int AXI_ADDR_W = 14;
    localparam int AXI_DATA_W = 32;

    // Register map
    localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR   = 14'h0000;
    localparam logic [AXI_ADDR_W-1:0] STATUS_ADDR = 14'h0004;
    localparam logic [AXI_ADDR_W-1:0] FB_BASE     = 14'h1000;

    typedef struct packed {
        logic [AXI_DATA_W-2:0] rsvd;
        logic                  run;
    } ctrl_view_t;

    // Even sample sits in the low half
    typedef struct packed {
        logic [SAMPLE_W-1:0] hi;
        logic [SAMPLE_W-1:0] lo;
    } pair_view_t;

    // Same write word, decoded by target address
    typedef union packed {
        ctrl_view_t ctrl;
        pair_view_t pair;
    } axil_word_u;

    typedef enum logic [1:0] {
        IDLE,
        DISPLAY,
        DRAIN
    } disp_state_e;

endpackage

/* rtl/scan_if.sv */
`timescale 1ns/1ps

interface scan_if #(
    parameter int H_W = 10,
    parameter int V_W = 10
);
    // Raster position and syncs, all registered at the source
    logic [H_W-1:0] h_pos;
    logic [V_W-1:0] v_pos;
    logic           img_active;
    logic           hsync;
    logic           vsync;

    modport source (output h_pos, v_pos, img_active, hsync, vsync);
    modport sink   (input  h_pos, v_pos, img_active, hsync, vsync);

endinterface

/* rtl/heatmap_regs.sv */
`timescale 1ns/1ps

module heatmap_regs #(
    parameter int FB_DEPTH = 4800
) (
    input  logic                                i_clk_25M,
    input  logic                                i_rst,
    input  logic [heatmap_pkg::AXI_ADDR_W-1:0]  i_awaddr,
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [heatmap_pkg::AXI_DATA_W-1:0]  i_wdata,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    output logic [1:0]                          o_bresp,
    output logic                                o_bvalid,
    input  logic                                i_bready,
    input  logic [heatmap_pkg::AXI_ADDR_W-1:0]  i_araddr,
    input  logic                                i_arvalid,
    output logic                                o_arready,
    output logic [heatmap_pkg::AXI_DATA_W-1:0]  o_rdata,
    output logic [1:0]                          o_rresp,
    output logic                                o_rvalid,
    input  logic                                i_rready,
    output logic                                o_fb_we,
    output logic [$clog2(FB_DEPTH/2)-1:0]       o_fb_waddr,
    output logic [heatmap_pkg::AXI_DATA_W-1:0]  o_fb_wdata,
    output logic                                o_run,
    input  logic                                i_displaying,
    input  logic [15:0]                         i_frame_count
);
    import heatmap_pkg::*;

    localparam int PAIR_AW = $clog2(FB_DEPTH / 2);

    axil_word_u            wword;
    logic                  busy;
    logic                  wr_start;
    logic                  rd_start;
    logic [AXI_ADDR_W-1:0] wr_off;
    logic                  fb_hit;
    logic [AXI_DATA_W-1:0] rd_word;

    // One transaction in flight, writes win a tie
    assign busy     = o_awready | o_arready | o_bvalid | o_rvalid;
    assign wr_start = i_awvalid & i_wvalid & ~busy;
    assign rd_start = i_arvalid & ~busy & ~wr_start;

    assign wword  = i_wdata;
    assign wr_off = i_awaddr - FB_BASE;
    assign fb_hit = (i_awaddr >= FB_BASE) && (wr_off[AXI_ADDR_W-1:2] < FB_DEPTH / 2);

    // Sample pair lands in the RAM during the handshake cycle
    assign o_fb_we    = o_awready & fb_hit;
    assign o_fb_waddr = wr_off[PAIR_AW+1:2];
    assign o_fb_wdata = {wword.pair.hi, wword.pair.lo};

    assign o_wready = o_awready;
    assign o_bresp  = 2'b00;
    assign o_rresp  = 2'b00;

    always_comb begin
        case (i_araddr)
            CTRL_ADDR:   rd_word = {{(AXI_DATA_W-1){1'b0}}, o_run};
            STATUS_ADDR: rd_word = {i_frame_count, 15'd0, i_displaying};
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            o_awready <= 1'b0;
            o_arready <= 1'b0;
            o_bvalid  <= 1'b0;
            o_rvalid  <= 1'b0;
            o_run     <= 1'b0;
        end else begin
            o_awready <= wr_start;
            o_arready <= rd_start;
            if (o_awready) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (o_arready) begin
                o_rvalid <= 1'b1;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
            if (o_awready && i_awaddr == CTRL_ADDR) begin
                o_run <= wword.ctrl.run;
            end
        end
    end

    always_ff @(posedge i_clk_25M) begin
        if (o_arready) begin
            o_rdata <= rd_word;
        end
    end

    // A write response always follows a write handshake
    a_bvalid_after_accept: assert property (
        @(posedge i_clk_25M) disable iff (i_rst)
        $rose(o_bvalid) |-> $past(o_awready & i_awvalid & i_wvalid)
    );

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer #(
    parameter int DEPTH = 4800
) (
    input  logic                               i_clk_25M,
    input  logic                               i_we,
    input  logic [$clog2(DEPTH/2)-1:0]         i_waddr,
    input  logic [2*heatmap_pkg::SAMPLE_W-1:0] i_wdata,
    input  logic [$clog2(DEPTH)-1:0]           i_raddr,
    output logic [heatmap_pkg::SAMPLE_W-1:0]   o_rdata
);
    import heatmap_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // One word per sample pair
    logic [2*SAMPLE_W-1:0] mem [DEPTH/2];
    logic [2*SAMPLE_W-1:0] rd_pair;
    logic                  rd_odd;

    always_ff @(posedge i_clk_25M) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        rd_pair <= mem[i_raddr[AW-1:1]];
        rd_odd  <= i_raddr[0];
    end

    assign o_rdata = rd_odd ? rd_pair[2*SAMPLE_W-1:SAMPLE_W] : rd_pair[SAMPLE_W-1:0];

    a_waddr_range: assert property (@(posedge i_clk_25M) i_we |-> i_waddr < DEPTH / 2);

endmodule

/* rtl/display_fsm.sv */
`timescale 1ns/1ps

module display_fsm (
    input  logic        i_clk_25M,
    input  logic        i_rst,
    input  logic        i_run,
    input  logic        i_frame_end,
    output logic        o_scan_en,
    output logic        o_displaying,
    output logic [15:0] o_frame_count,
    output logic        o_frame_done
);
    import heatmap_pkg::*;

    disp_state_e state;
    disp_state_e state_nxt;
    logic [2:0]  done_dly;
    logic        last_frame;

    // Stop request meets the end of a frame, keep the timer from wrapping
    assign last_frame   = i_frame_end & ~i_run;
    assign o_scan_en    = (state != IDLE) & ~last_frame;
    assign o_displaying = (state != IDLE);
    // Three stages to line up with the pixel pipeline
    assign o_frame_done = done_dly[2];

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_run) begin
                    state_nxt = DISPLAY;
                end
            end
            default: begin
                if (last_frame) begin
                    state_nxt = IDLE;
                end else if (!i_run) begin
                    state_nxt = DRAIN;
                end else begin
                    state_nxt = DISPLAY;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            state         <= IDLE;
            done_dly      <= '0;
            o_frame_count <= '0;
        end else begin
            state    <= state_nxt;
            done_dly <= {done_dly[1:0], i_frame_end};
            if (i_frame_end) begin
                o_frame_count <= o_frame_count + 16'd1;
            end
        end
    end

    // Timer must be idle whenever this controller is
    a_no_frame_end_idle: assert property (
        @(posedge i_clk_25M) disable iff (i_rst)
        i_frame_end |-> state != IDLE
    );

endmodule

/* rtl/scan_timer.sv */
`timescale 1ns/1ps

module scan_timer #(
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int H_TOTAL    = 800,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int V_TOTAL    = 525,
    parameter int IMG_COLS   = 80,
    parameter int IMG_ROWS   = 60,
    parameter int SCALE_LOG2 = 2
) (
    input  logic   i_clk_25M,
    input  logic   i_rst,
    input  logic   i_scan_en,
    output logic   o_frame_end,
    scan_if.source scan
);
    localparam int H_W    = $clog2(H_TOTAL);
    localparam int V_W    = $clog2(V_TOTAL);
    localparam int H_IMG0 = H_SYNC + H_BACK;
    localparam int V_IMG0 = V_SYNC + V_BACK;
    localparam int H_IMG1 = H_IMG0 + (IMG_COLS << SCALE_LOG2);
    localparam int V_IMG1 = V_IMG0 + (IMG_ROWS << SCALE_LOG2);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_last;
    logic           v_last;

    assign h_last = (h_cnt == H_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == V_W'(V_TOTAL - 1));

    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            h_cnt           <= '0;
            v_cnt           <= '0;
            scan.h_pos      <= '0;
            scan.v_pos      <= '0;
            scan.hsync      <= 1'b1;
            scan.vsync      <= 1'b1;
            scan.img_active <= 1'b0;
            o_frame_end     <= 1'b0;
        end else if (!i_scan_en) begin
            h_cnt           <= '0;
            v_cnt           <= '0;
            scan.h_pos      <= '0;
            scan.v_pos      <= '0;
            scan.hsync      <= 1'b1;
            scan.vsync      <= 1'b1;
            scan.img_active <= 1'b0;
            o_frame_end     <= 1'b0;
        end else begin
            // Outputs carry the current count while the counters move on
            scan.h_pos      <= h_cnt;
            scan.v_pos      <= v_cnt;
            scan.hsync      <= (h_cnt >= H_SYNC);
            scan.vsync      <= (v_cnt >= V_SYNC);
            scan.img_active <= (h_cnt >= H_IMG0) && (h_cnt < H_IMG1) &&
                               (v_cnt >= V_IMG0) && (v_cnt < V_IMG1);
            o_frame_end     <= h_last && v_last;
            h_cnt           <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    a_h_in_range: assert property (
        @(posedge i_clk_25M) disable iff (i_rst)
        h_cnt < H_TOTAL
    );

endmodule

/* rtl/pixel_colormap.sv */
`timescale 1ns/1ps

module pixel_colormap #(
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int IMG_COLS   = 80,
    parameter int IMG_ROWS   = 60,
    parameter int SCALE_LOG2 = 2
) (
    input  logic                                i_clk_25M,
    input  logic                                i_rst,
    scan_if.sink                                scan,
    output logic [$clog2(IMG_COLS*IMG_ROWS)-1:0] o_raddr,
    input  logic [heatmap_pkg::SAMPLE_W-1:0]    i_rdata,
    output logic [heatmap_pkg::COLOR_W-1:0]     o_vga_r,
    output logic [heatmap_pkg::COLOR_W-1:0]     o_vga_g,
    output logic [heatmap_pkg::COLOR_W-1:0]     o_vga_b,
    output logic                                o_vga_hs,
    output logic                                o_vga_vs
);
    import heatmap_pkg::*;

    localparam int AW   = $clog2(IMG_COLS * IMG_ROWS);
    localparam int HALF = 32767;

    logic [31:0]        blk_col;
    logic [31:0]        blk_row;
    logic [31:0]        lo_part;
    logic [31:0]        hi_part;
    logic [COLOR_W-1:0] cm_r;
    logic [COLOR_W-1:0] cm_g;
    logic [COLOR_W-1:0] cm_b;
    logic               s1_active;
    logic               s1_hs;
    logic               s1_vs;
    logic               s2_active;
    logic               s2_hs;
    logic               s2_vs;

    // Block indices relative to the image origin
    assign blk_col = (32'(scan.h_pos) - (H_SYNC + H_BACK)) >> SCALE_LOG2;
    assign blk_row = (32'(scan.v_pos) - (V_SYNC + V_BACK)) >> SCALE_LOG2;

    // Stage 1, sample address
    always_ff @(posedge i_clk_25M) begin
        if (scan.img_active) begin
            o_raddr <= AW'(blk_row * IMG_COLS + blk_col);
        end
    end

    // Blue to green up to half scale, green to red above it
    assign lo_part = (32'd255 * 32'(i_rdata)) / 32'(HALF);
    assign hi_part = (32'd255 * (32'(i_rdata) - 32'(HALF))) / 32'(HALF + 1);

    always_comb begin
        if (i_rdata <= HALF) begin
            cm_r = '0;
            cm_g = COLOR_W'(lo_part);
            cm_b = 8'd255 - COLOR_W'(lo_part);
        end else begin
            cm_r = COLOR_W'(hi_part);
            cm_g = 8'd255 - COLOR_W'(hi_part);
            cm_b = '0;
        end
    end

    // Stage 2 waits on the RAM, stage 3 colours or blanks
    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            s1_active <= 1'b0;
            s1_hs     <= 1'b1;
            s1_vs     <= 1'b1;
            s2_active <= 1'b0;
            s2_hs     <= 1'b1;
            s2_vs     <= 1'b1;
            o_vga_hs  <= 1'b1;
            o_vga_vs  <= 1'b1;
            o_vga_r   <= '0;
            o_vga_g   <= '0;
            o_vga_b   <= '0;
        end else begin
            s1_active <= scan.img_active;
            s1_hs     <= scan.hsync;
            s1_vs     <= scan.vsync;
            s2_active <= s1_active;
            s2_hs     <= s1_hs;
            s2_vs     <= s1_vs;
            o_vga_hs  <= s2_hs;
            o_vga_vs  <= s2_vs;
            o_vga_r   <= s2_active ? cm_r : '0;
            o_vga_g   <= s2_active ? cm_g : '0;
            o_vga_b   <= s2_active ? cm_b : '0;
        end
    end

endmodule

/* rtl/heatmap_vga_top.sv */
`timescale 1ns/1ps

module heatmap_vga_top #(
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int H_TOTAL    = 800,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int V_TOTAL    = 525,
    parameter int IMG_COLS   = 80,
    parameter int IMG_ROWS   = 60,
    parameter int SCALE_LOG2 = 2
) (
    input  logic                               i_clk_25M,
    input  logic                               i_rst,
    input  logic [heatmap_pkg::AXI_ADDR_W-1:0] i_awaddr,
    input  logic                               i_awvalid,
    output logic                               o_awready,
    input  logic [heatmap_pkg::AXI_DATA_W-1:0] i_wdata,
    input  logic                               i_wvalid,
    output logic                               o_wready,
    output logic [1:0]                         o_bresp,
    output logic                               o_bvalid,
    input  logic                               i_bready,
    input  logic [heatmap_pkg::AXI_ADDR_W-1:0] i_araddr,
    input  logic                               i_arvalid,
    output logic                               o_arready,
    output logic [heatmap_pkg::AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]                         o_rresp,
    output logic                               o_rvalid,
    input  logic                               i_rready,
    output logic                               o_vga_clk,
    output logic                               o_vga_hs,
    output logic                               o_vga_vs,
    output logic [heatmap_pkg::COLOR_W-1:0]    o_vga_r,
    output logic [heatmap_pkg::COLOR_W-1:0]    o_vga_g,
    output logic [heatmap_pkg::COLOR_W-1:0]    o_vga_b,
    output logic                               o_frame_done
);
    import heatmap_pkg::*;

    localparam int FB_DEPTH = IMG_COLS * IMG_ROWS;
    localparam int FB_AW    = $clog2(FB_DEPTH);
    localparam int FB_PAW   = $clog2(FB_DEPTH / 2);

    logic                  fb_we;
    logic [FB_PAW-1:0]     fb_waddr;
    logic [AXI_DATA_W-1:0] fb_wdata;
    logic [FB_AW-1:0]      fb_raddr;
    logic [SAMPLE_W-1:0]   fb_rdata;
    logic                  run;
    logic                  displaying;
    logic                  scan_en;
    logic                  frame_end;
    logic [15:0]           frame_count;

    scan_if #(.H_W($clog2(H_TOTAL)), .V_W($clog2(V_TOTAL))) u_scan_if ();

    // Pixel clock goes straight to the DAC
    assign o_vga_clk = i_clk_25M;

    heatmap_regs #(.FB_DEPTH(FB_DEPTH)) u_heatmap_regs (
        .i_clk_25M     (i_clk_25M),
        .i_rst         (i_rst),
        .i_awaddr      (i_awaddr),
        .i_awvalid     (i_awvalid),
        .o_awready     (o_awready),
        .i_wdata       (i_wdata),
        .i_wvalid      (i_wvalid),
        .o_wready      (o_wready),
        .o_bresp       (o_bresp),
        .o_bvalid      (o_bvalid),
        .i_bready      (i_bready),
        .i_araddr      (i_araddr),
        .i_arvalid     (i_arvalid),
        .o_arready     (o_arready),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .o_rvalid      (o_rvalid),
        .i_rready      (i_rready),
        .o_fb_we       (fb_we),
        .o_fb_waddr    (fb_waddr),
        .o_fb_wdata    (fb_wdata),
        .o_run         (run),
        .i_displaying  (displaying),
        .i_frame_count (frame_count)
    );

    frame_buffer #(.DEPTH(FB_DEPTH)) u_frame_buffer (
        .i_clk_25M (i_clk_25M),
        .i_we      (fb_we),
        .i_waddr   (fb_waddr),
        .i_wdata   (fb_wdata),
        .i_raddr   (fb_raddr),
        .o_rdata   (fb_rdata)
    );

    display_fsm u_display_fsm (
        .i_clk_25M     (i_clk_25M),
        .i_rst         (i_rst),
        .i_run         (run),
        .i_frame_end   (frame_end),
        .o_scan_en     (scan_en),
        .o_displaying  (displaying),
        .o_frame_count (frame_count),
        .o_frame_done  (o_frame_done)
    );

    scan_timer #(
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .H_TOTAL    (H_TOTAL),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK),
        .V_TOTAL    (V_TOTAL),
        .IMG_COLS   (IMG_COLS),
        .IMG_ROWS   (IMG_ROWS),
        .SCALE_LOG2 (SCALE_LOG2)
    ) u_scan_timer (
        .i_clk_25M   (i_clk_25M),
        .i_rst       (i_rst),
        .i_scan_en   (scan_en),
        .o_frame_end (frame_end),
        .scan        (u_scan_if.source)
    );

    pixel_colormap #(
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK),
        .IMG_COLS   (IMG_COLS),
        .IMG_ROWS   (IMG_ROWS),
        .SCALE_LOG2 (SCALE_LOG2)
    ) u_pixel_colormap (
        .i_clk_25M (i_clk_25M),
        .i_rst     (i_rst),
        .scan      (u_scan_if.sink),
        .o_raddr   (fb_raddr),
        .i_rdata   (fb_rdata),
        .o_vga_r   (o_vga_r),
        .o_vga_g   (o_vga_g),
        .o_vga_b   (o_vga_b),
        .o_vga_hs  (o_vga_hs),
        .o_vga_vs  (o_vga_vs)
    );

endmodule

/* include/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// One AXI4-Lite write, response must be OKAY
task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr,
                          input logic [AXI_DATA_W-1:0] data);
    @(posedge clk_25M);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    do begin
        @(negedge clk_25M);
    end while (!awready);
    assert (wready) else report_error("WREADY did not rise together with AWREADY");
    @(posedge clk_25M);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do begin
        @(negedge clk_25M);
    end while (!bvalid);
    assert (bresp == 2'b00) else report_mismatch("axil_write", "BRESP", 32'd0, 32'(bresp));
    @(posedge clk_25M);
    bready <= 1'b0;
endtask

// One AXI4-Lite read, data taken while RVALID is high
task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr,
                         output logic [AXI_DATA_W-1:0] data);
    @(posedge clk_25M);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do begin
        @(negedge clk_25M);
    end while (!arready);
    @(posedge clk_25M);
    arvalid <= 1'b0;
    do begin
        @(negedge clk_25M);
    end while (!rvalid);
    data = rdata;
    assert (rresp == 2'b00) else report_mismatch("axil_read", "RRESP", 32'd0, 32'(rresp));
    @(posedge clk_25M);
    rready <= 1'b0;
endtask

// Blue to green to red, packed as {r, g, b}
function automatic logic [23:0] colormap_ref(input int unsigned d);
    int unsigned r;
    int unsigned g;
    int unsigned b;
    if (d <= 32767) begin
        r = 0;
        g = (255 * d) / 32767;
        b = 255 - g;
    end else begin
        r = (255 * (d - 32767)) / 32768;
        g = 255 - r;
        b = 0;
    end
    return {r[7:0], g[7:0], b[7:0]};
endfunction

`endif

/* sim/tb_heatmap_vga.sv */
`timescale 1ns/1ps

module tb_heatmap_vga;
    import heatmap_pkg::*;

    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 4;
    localparam int H_TOTAL      = 40;
    localparam int V_SYNC       = 1;
    localparam int V_BACK       = 2;
    localparam int V_TOTAL      = 20;
    localparam int IMG_COLS     = 8;
    localparam int IMG_ROWS     = 6;
    localparam int SCALE_LOG2   = 1;
    localparam int CLK_PERIOD   = 40;
    localparam int FB_DEPTH     = IMG_COLS * IMG_ROWS;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int IMG_H0       = H_SYNC + H_BACK;
    localparam int IMG_V0       = V_SYNC + V_BACK;
    // Ten frames cover every test with room for the AXI traffic
    localparam int WATCHDOG_NS  = (10 * FRAME_CYCLES + 1000) * CLK_PERIOD;

    logic                  clk_25M = 1'b0;
    logic                  rst;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  vga_clk;
    logic                  vga_hs;
    logic                  vga_vs;
    logic [COLOR_W-1:0]    vga_r;
    logic [COLOR_W-1:0]    vga_g;
    logic [COLOR_W-1:0]    vga_b;
    logic                  frame_done;

    int          cycle = 0;
    int          done_count = 0;
    logic [31:0] rng_state = 32'h2798c5bd;
    logic [15:0] samples [FB_DEPTH];

    always #(CLK_PERIOD / 2) clk_25M = ~clk_25M;

    always @(posedge clk_25M) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk_25M) begin
        if (frame_done) begin
            done_count <= done_count + 1;
        end
    end

    heatmap_vga_top #(
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .H_TOTAL    (H_TOTAL),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK),
        .V_TOTAL    (V_TOTAL),
        .IMG_COLS   (IMG_COLS),
        .IMG_ROWS   (IMG_ROWS),
        .SCALE_LOG2 (SCALE_LOG2)
    ) u_heatmap_vga_top (
        .i_clk_25M    (clk_25M),
        .i_rst        (rst),
        .i_awaddr     (awaddr),
        .i_awvalid    (awvalid),
        .o_awready    (awready),
        .i_wdata      (wdata),
        .i_wvalid     (wvalid),
        .o_wready     (wready),
        .o_bresp      (bresp),
        .o_bvalid     (bvalid),
        .i_bready     (bready),
        .i_araddr     (araddr),
        .i_arvalid    (arvalid),
        .o_arready    (arready),
        .o_rdata      (rdata),
        .o_rresp      (rresp),
        .o_rvalid     (rvalid),
        .i_rready     (rready),
        .o_vga_clk    (vga_clk),
        .o_vga_hs     (vga_hs),
        .o_vga_vs     (vga_vs),
        .o_vga_r      (vga_r),
        .o_vga_g      (vga_g),
        .o_vga_b      (vga_b),
        .o_frame_done (frame_done)
    );

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Fail %s: %s expected 0x%08h actual 0x%08h", test, what, expected, actual);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_axil_tasks.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Pixel at a line and column counted from the sync falls
    function automatic logic [23:0] expected_pixel(input int line, input int col);
        int blk;
        if (col < IMG_H0 || col >= IMG_H0 + (IMG_COLS << SCALE_LOG2) ||
            line < IMG_V0 || line >= IMG_V0 + (IMG_ROWS << SCALE_LOG2)) begin
            return 24'h0;
        end
        blk = ((line - IMG_V0) >> SCALE_LOG2) * IMG_COLS + ((col - IMG_H0) >> SCALE_LOG2);
        return colormap_ref(samples[blk]);
    endfunction

    // Returns at the first negedge where the chosen sync is low again
    task automatic wait_sync_fall(input bit vertical);
        logic prev;
        logic cur;
        cur = vertical ? vga_vs : vga_hs;
        do begin
            prev = cur;
            @(negedge clk_25M);
            cur = vertical ? vga_vs : vga_hs;
        end while (!(prev && !cur));
    endtask

    task automatic measure_sync(input bit vertical, output int low_len, output int period);
        int t0;
        wait_sync_fall(vertical);
        t0 = cycle;
        do begin
            @(negedge clk_25M);
        end while (!(vertical ? vga_vs : vga_hs));
        low_len = cycle - t0;
        wait_sync_fall(vertical);
        period = cycle - t0;
    endtask

    task automatic test_reset_state();
        logic [31:0] status;
        // Pixel clock follows the input clock in both phases
        @(posedge clk_25M);
        #(CLK_PERIOD / 4);
        assert (vga_clk == 1'b1) else report_error("VGA clock low while the input clock is high");
        @(negedge clk_25M);
        #(CLK_PERIOD / 4);
        assert (vga_clk == 1'b0) else report_error("VGA clock high while the input clock is low");
        @(negedge clk_25M);
        assert (vga_hs && vga_vs) else report_error("syncs not high after reset");
        assert ({vga_r, vga_g, vga_b} == 24'h0)
            else report_mismatch("reset_state", "RGB", 32'h0, {vga_r, vga_g, vga_b});
        assert (!frame_done) else report_error("frame done pulse seen during reset state");
        assert (!awready && !wready && !bvalid && !arready && !rvalid)
            else report_error("AXI handshake outputs active after reset");
        axil_read(STATUS_ADDR, status);
        assert (status == 32'h0) else report_mismatch("reset_state", "STATUS", 32'h0, status);
    endtask

    task automatic test_register_access();
        logic [31:0] value;
        axil_write(CTRL_ADDR, 32'h1);
        axil_read(CTRL_ADDR, value);
        assert (value == 32'h1) else report_mismatch("register_access", "CTRL", 32'h1, value);
        axil_read(14'h0008, value);
        assert (value == 32'h0) else report_mismatch("register_access", "unmapped", 32'h0, value);
        axil_read(FB_BASE, value);
        assert (value == 32'h0) else report_mismatch("register_access", "FB read", 32'h0, value);
    endtask

    task automatic test_sync_timing();
        int low_len;
        int period;
        repeat (3) begin
            measure_sync(1'b0, low_len, period);
            assert (low_len == H_SYNC)
                else report_mismatch("sync_timing", "hsync low cycles", H_SYNC, low_len);
            assert (period == H_TOTAL)
                else report_mismatch("sync_timing", "hsync period", H_TOTAL, period);
        end
        measure_sync(1'b1, low_len, period);
        assert (low_len == V_SYNC * H_TOTAL)
            else report_mismatch("sync_timing", "vsync low cycles", V_SYNC * H_TOTAL, low_len);
        assert (period == FRAME_CYCLES)
            else report_mismatch("sync_timing", "vsync period", FRAME_CYCLES, period);
    endtask

    task automatic test_image_content();
        int          line;
        int          col;
        logic        prev_hs;
        logic [23:0] exp_rgb;
        for (int i = 0; i < FB_DEPTH; i++) begin
            rng_state  = xorshift32(rng_state);
            samples[i] = rng_state[31:16];
        end
        // Colormap corners at both ends and around half scale
        samples[0] = 16'h0000;
        samples[1] = 16'h7fff;
        samples[2] = 16'h8000;
        samples[3] = 16'hffff;
        for (int k = 0; k < FB_DEPTH / 2; k++) begin
            axil_write(FB_BASE + AXI_ADDR_W'(4 * k), {samples[2*k+1], samples[2*k]});
        end
        wait_sync_fall(1'b1);
        line    = 0;
        col     = 0;
        prev_hs = vga_hs;
        repeat (FRAME_CYCLES) begin
            exp_rgb = expected_pixel(line, col);
            assert ({vga_r, vga_g, vga_b} == exp_rgb)
                else report_mismatch("image_content",
                                     $sformatf("pixel line %0d col %0d", line, col),
                                     exp_rgb, {vga_r, vga_g, vga_b});
            @(negedge clk_25M);
            if (prev_hs && !vga_hs) begin
                line++;
                col = 0;
            end else begin
                col++;
            end
            prev_hs = vga_hs;
        end
    endtask

    task automatic test_stop_and_count();
        int          t0;
        int          hs_falls;
        int          run_len;
        logic        prev_hs;
        logic [31:0] status;
        wait_sync_fall(1'b1);
        t0       = cycle;
        hs_falls = 0;
        fork
            begin
                prev_hs = vga_hs;
                do begin
                    @(negedge clk_25M);
                    if (prev_hs && !vga_hs) begin
                        hs_falls++;
                    end
                    prev_hs = vga_hs;
                end while (!frame_done);
            end
            begin
                repeat (FRAME_CYCLES / 4) @(negedge clk_25M);
                axil_write(CTRL_ADDR, 32'h0);
            end
        join
        // Frame done lines up with the last pixel of the last line
        run_len = cycle - t0;
        assert (run_len == FRAME_CYCLES - 1)
            else report_mismatch("stop_and_count", "cycles to frame done", FRAME_CYCLES - 1, run_len);
        assert (hs_falls == V_TOTAL - 1)
            else report_mismatch("stop_and_count", "lines after vsync", V_TOTAL - 1, hs_falls);
        repeat (3 * H_TOTAL) begin
            @(negedge clk_25M);
            assert (vga_hs && vga_vs) else report_error("syncs still active after stop");
        end
        axil_read(STATUS_ADDR, status);
        assert (status == {done_count[15:0], 16'h0000})
            else report_mismatch("stop_and_count", "STATUS", {done_count[15:0], 16'h0000}, status);
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_error("watchdog expired before the tests completed");
    end

    initial begin
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (4) @(posedge clk_25M);
        rst <= 1'b0;
        test_reset_state();
        test_register_access();
        test_sync_timing();
        test_image_content();
        test_stop_and_count();
        $display("** PASS **");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
rtl/heatmap_pkg.sv
rtl/scan_if.sv
rtl/heatmap_regs.sv
rtl/frame_buffer.sv
rtl/display_fsm.sv
rtl/scan_timer.sv
rtl/pixel_colormap.sv
rtl/heatmap_vga_top.sv
sim/tb_heatmap_vga.sv
